/* all.f */
+incdir+common
common/noise_pkg.sv
reader/block_reader.sv
logic/block_activity.sv
logic/noise_tracker.sv
logic/noise_estimation_top.sv
bench/frame_memory_model.sv
bench/noise_tb.sv

/* bench/noise_tb.sv */
// testbench for the noise estimation top level, random frames through a memory
// model and checked against a reference model of block order and activity
`default_nettype none
`include "noise_params.svh"

module noise_tb import noise_pkg::*; ();

	localparam int NUM_FRAMES = 6;
	localparam int BS         = `BLOCK_SIZE;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                frame_ready;
	logic [`DIM_W-1:0]   frame_width;
	logic [`DIM_W-1:0]   frame_height;
	logic [`ADDR_W-1:0]  frame_base;
	logic                rvalid;
	logic [`PIXEL_W-1:0] rdata;
	logic                rlast;
	logic                estimated_noise_ready;
	read_req_t           read_req;
	logic                noise_estimation_en;
	logic                start_of_frame;
	logic                start_data;
	logic                result_valid;
	noise_result_t       result;
	logic                gap;
	logic [`PIXEL_W-1:0] pixel;
	logic [`ADDR_W-1:0]  beat_addr;

	logic [31:0] lfsr_state = 32'h5d02;
	int          fw [NUM_FRAMES];
	int          fh [NUM_FRAMES];
	logic [31:0] fbase [NUM_FRAMES];
	int          ack_delay [NUM_FRAMES];
	read_req_t   exp_req [$];      // bursts still due in the current frame
	int          cycle = 0;
	int          limit = 0;
	int          starts_seen = 0;
	int          sof_count = 0;
	int          sd_count = 0;
	logic        en_prev = 1'b0;   // noise_estimation_en at the last falling edge

	always #50 clk = ~clk;

	noise_estimation_top dut (.*);
	frame_memory_model mem (.*);

	// Fibonacci LFSR with taps at bits 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r          = {r[30:0], fb};
		end
		return r;
	endfunction

	// memory contents from a scrambled address run through a few LFSR steps
	function automatic logic [`PIXEL_W-1:0] pixel_at(input logic [`ADDR_W-1:0] a);
		logic [31:0] s;
		s = (a * 32'h9e37_79b1) ^ 32'h5d02;
		for (int i = 0; i < 8; i++) begin
			s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
		end
		return s[`PIXEL_W-1:0];
	endfunction

	assign pixel = pixel_at(beat_addr);

	task automatic report_error(input string msg);
		$display("** Error at time %0t: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string msg);
		$display("Failure at time %0t: %s", $time, msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_req(input read_req_t got, input read_req_t exp);
		if (got !== exp) begin
			report_error($sformatf("read request addr %h len %0d, expected addr %h len %0d",
				got.addr, got.len, exp.addr, exp.len));
		end
	endtask

	task automatic check_result(input noise_result_t got, input noise_result_t exp);
		if (got !== exp) begin
			report_error($sformatf("estimate %0d base %h, expected estimate %0d base %h",
				got.estimate, got.base_addr, exp.estimate, exp.base_addr));
		end
	endtask

	task automatic check_idle(input string when);
		if (read_req.start || noise_estimation_en || start_of_frame || start_data
			|| result_valid) begin
			report_failure({"a control output or result_valid is high ", when});
		end
	endtask

	// queue the bursts in row-major block order and find the flattest block
	task automatic model_frame(input int f, output noise_result_t exp_res);
		read_req_t   req;
		logic [31:0] row_addr;
		int          act;
		int          d;
		int          best;
		best = 32'h7fff_ffff;
		for (int by = 0; by < fh[f] / BS; by++) begin
			for (int bx = 0; bx < fw[f] / BS; bx++) begin
				act = 0;
				for (int y = 0; y < BS; y++) begin
					row_addr = fbase[f] + (by * BS + y) * fw[f] + bx * BS;
					req      = '{start: 1'b1, addr: row_addr, len: `LEN_W'(BS)};
					exp_req.push_back(req);
					for (int x = 1; x < BS; x++) begin
						d   = int'(pixel_at(row_addr + x)) - int'(pixel_at(row_addr + x - 1));
						act = act + ((d < 0) ? -d : d);
					end
				end
				best = (act < best) ? act : best;
			end
		end
		exp_res = '{estimate: `ACT_W'(best), base_addr: fbase[f]};
	endtask

	// keep the estimate waiting a while, then take it with a one-cycle pulse
	task automatic acknowledge_result(input noise_result_t exp_res, input int delay);
		for (int i = 0; i < delay; i++) begin
			@(negedge clk);
			if (!result_valid) begin
				report_failure("result_valid dropped before estimated_noise_ready");
			end
		end
		check_result(result, exp_res);
		estimated_noise_ready <= 1'b1;
		@(negedge clk);
		estimated_noise_ready <= 1'b0;
		if (result_valid) begin
			report_failure("result_valid still high after estimated_noise_ready");
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > limit) begin
			report_failure("timeout, the frames did not finish within the cycle limit");
		end
	end

	// hold rvalid low on about one falling edge in four
	always @(negedge clk) begin
		gap <= (rand_bits(2) == 2'b00);
	end

	always @(negedge clk) begin
		if (rst_n) begin
			if (read_req.start) begin
				if (result_valid) begin
					report_failure("read started while the previous estimate was still held");
				end else if (exp_req.size() == 0) begin
					report_failure("read started with no burst left in the model");
				end else begin
					check_req(read_req, exp_req.pop_front());
				end
				starts_seen++;
			end else if (rvalid && rlast && exp_req.size() != 0) begin
				report_failure("next burst did not start one cycle after rlast");
			end
			if (rvalid && !en_prev) begin
				report_failure("rvalid beat while noise_estimation_en was low");
			end
			sof_count += start_of_frame;
			sd_count  += start_data;
		end
		en_prev = noise_estimation_en;
	end

	initial begin
		noise_result_t exp_res;
		noise_result_t held;
		int            total_beats;
		int            sof_before;
		int            sd_before;
		int            starts_before;
		rst_n                 = 1'b0;
		frame_ready           = 1'b0;
		frame_width           = `DIM_W'(BS);
		frame_height          = `DIM_W'(BS);
		frame_base            = '0;
		estimated_noise_ready = 1'b0;
		gap                   = 1'b0;
		total_beats           = 0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			fw[f]        = BS * (int'(rand_bits(2)) + 1);
			fh[f]        = BS * (int'(rand_bits(2)) + 1);
			fbase[f]     = rand_bits(32);
			ack_delay[f] = int'(rand_bits(4));
			if (f == NUM_FRAMES - 1) begin
				fw[f] = BS;   // single block frame
				fh[f] = BS;
			end
			total_beats += fw[f] * fh[f];
		end
		limit = total_beats * 4 + 2000;

		repeat (16) @(negedge clk);
		check_idle("during reset");
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle("after reset");

		for (int f = 0; f < NUM_FRAMES; f++) begin
			model_frame(f, exp_res);
			sof_before    = sof_count;
			sd_before     = sd_count;
			starts_before = starts_seen;
			frame_width   <= `DIM_W'(fw[f]);
			frame_height  <= `DIM_W'(fh[f]);
			frame_base    <= fbase[f];
			frame_ready   <= 1'b1;
			// frame_ready is already up while the previous estimate waits
			if (f > 0) begin
				acknowledge_result(held, ack_delay[f - 1]);
			end
			while (starts_seen == starts_before) begin
				@(negedge clk);
			end
			frame_ready <= 1'b0;
			while (!result_valid) begin
				@(negedge clk);
			end
			check_result(result, exp_res);
			if (sof_count - sof_before != 1
				|| sd_count - sd_before != (fw[f] / BS) * (fh[f] / BS)) begin
				report_error($sformatf("frame %0d gave %0d start_of_frame and %0d start_data",
					f, sof_count - sof_before, sd_count - sd_before));
			end
			if (exp_req.size() != 0) begin
				report_failure("frame ended before all of its bursts were requested");
			end
			held = exp_res;
		end
		acknowledge_result(held, ack_delay[NUM_FRAMES - 1]);
		check_idle("after the last frame");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/frame_memory_model.sv */
// read memory model for the testbench, answers each start strobe with BLOCK_SIZE
// one-pixel beats and skips a beat while gap is high
`default_nettype none
`include "noise_params.svh"

module frame_memory_model import noise_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire read_req_t           read_req,
	input  wire logic                gap,        // no beat on this falling edge
	input  wire logic [`PIXEL_W-1:0] pixel,      // memory contents at beat_addr
	output logic [`ADDR_W-1:0]       beat_addr,
	output logic                     rvalid,
	output logic [`PIXEL_W-1:0]      rdata,
	output logic                     rlast
);

	int beats_left;

	// outputs move on the falling edge so the DUT sees them settled
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beats_left <= 0;
			beat_addr  <= '0;
			rvalid     <= 1'b0;
			rdata      <= '0;
			rlast      <= 1'b0;
		end else begin
			rvalid <= 1'b0;
			rlast  <= 1'b0;
			if (read_req.start) begin
				beat_addr  <= read_req.addr;   // first beat one edge later
				beats_left <= int'(read_req.len);
			end else if (beats_left > 0 && !gap) begin
				rvalid     <= 1'b1;
				rdata      <= pixel;
				rlast      <= (beats_left == 1);
				beat_addr  <= beat_addr + 1'b1;
				beats_left <= beats_left - 1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/noise_estimation_top.sv */
// noise estimation top: block reader, activity stage and minimum tracker
// frame geometry and base must stay steady while a frame is read
`default_nettype none
`include "noise_params.svh"

module noise_estimation_top import noise_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                frame_ready,
	input  wire logic [`DIM_W-1:0]   frame_width,
	input  wire logic [`DIM_W-1:0]   frame_height,
	input  wire logic [`ADDR_W-1:0]  frame_base,
	input  wire logic                rvalid,
	input  wire logic [`PIXEL_W-1:0] rdata,
	input  wire logic                rlast,
	input  wire logic                estimated_noise_ready,
	output read_req_t                read_req,
	output logic                     noise_estimation_en,
	output logic                     start_of_frame,
	output logic                     start_data,
	output logic                     result_valid,
	output noise_result_t            result
);

	pixel_beat_t beat;
	block_stat_t stat;
	logic        result_pending;

	block_reader u_reader (
		.clk                 (clk),
		.rst_n               (rst_n),
		.frame_ready         (frame_ready),
		.frame_width         (frame_width),
		.frame_height        (frame_height),
		.frame_base          (frame_base),
		.rvalid              (rvalid),
		.rlast               (rlast),
		.rdata               (rdata),
		.result_pending      (result_pending),
		.read_req            (read_req),
		.beat                (beat),
		.noise_estimation_en (noise_estimation_en),
		.start_of_frame      (start_of_frame),
		.start_data          (start_data)
	);

	block_activity u_activity (
		.clk   (clk),
		.rst_n (rst_n),
		.beat  (beat),
		.stat  (stat)
	);

	noise_tracker u_tracker (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.stat                  (stat),
		.frame_base            (frame_base),
		.estimated_noise_ready (estimated_noise_ready),
		.result_valid          (result_valid),
		.result_pending        (result_pending),
		.result                (result)
	);

endmodule

`default_nettype wire

/* logic/noise_tracker.sv */
// keeps the smallest block activity of a frame as its noise estimate
// and holds it until estimated_noise_ready takes it
`default_nettype none
`include "noise_params.svh"

module noise_tracker import noise_pkg::*; (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire block_stat_t        stat,
	input  wire logic [`ADDR_W-1:0] frame_base,  // steady while the frame is read
	input  wire logic               estimated_noise_ready,
	output logic                    result_valid,
	output logic                    result_pending,
	output noise_result_t           result
);

	logic               in_flight;    // frame has delivered statistics
	logic [`ACT_W-1:0]  min_q;
	logic [`ACT_W-1:0]  min_next;
	logic [`ADDR_W-1:0] base_q;
	logic [`ACT_W-1:0]  est_q;
	logic [`ADDR_W-1:0] res_base_q;

	// first statistic of a frame restarts the minimum
	assign min_next = (!in_flight || stat.activity < min_q) ? stat.activity : min_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_flight    <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			if (stat.valid) begin
				in_flight <= !stat.last_of_frame;
			end
			if (result_valid && estimated_noise_ready) begin
				result_valid <= 1'b0;
			end else if (stat.valid && stat.last_of_frame) begin
				result_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stat.valid) begin
			min_q <= min_next;
			if (!in_flight) begin
				base_q <= frame_base;
			end
			if (stat.last_of_frame) begin
				est_q      <= min_next;
				res_base_q <= in_flight ? base_q : frame_base;  // single block frame
			end
		end
	end

	assign result_pending = result_valid || in_flight;
	assign result         = '{estimate: est_q, base_addr: res_base_q};

	// reader must not start a frame while the estimate is held
	a_no_stat_while_held: assert property (@(posedge clk) disable iff (!rst_n)
		stat.valid |-> !result_valid);

endmodule

`default_nettype wire

/* logic/block_activity.sv */
// block activity: sum of absolute horizontal neighbour differences inside
// each block row, one statistic per 8x8 block
`default_nettype none
`include "noise_params.svh"

module block_activity import noise_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire pixel_beat_t beat,
	output block_stat_t      stat
);

	logic [`PIXEL_W-1:0] prev_pixel;   // left neighbour in the current row
	logic [`PIXEL_W-1:0] abs_diff;
	logic [`ACT_W-1:0]   sum_q;
	logic [`ACT_W-1:0]   sum_next;

	logic              stat_valid;
	logic              stat_last;
	logic [`ACT_W-1:0] stat_act;

	always_comb begin
		if (beat.pixel >= prev_pixel) begin
			abs_diff = beat.pixel - prev_pixel;
		end else begin
			abs_diff = prev_pixel - beat.pixel;
		end
	end

	// first pixel of a row has no left neighbour
	always_comb begin
		sum_next = beat.first_of_block ? '0 : sum_q;
		if (beat.px != '0) begin
			sum_next = sum_next + `ACT_W'(abs_diff);
		end
	end

	always_ff @(posedge clk) begin
		if (beat.valid) begin
			prev_pixel <= beat.pixel;
			sum_q      <= sum_next;
			if (beat.last_of_block) begin
				stat_act <= sum_next;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stat_valid <= 1'b0;
			stat_last  <= 1'b0;
		end else begin
			stat_valid <= beat.valid && beat.last_of_block;
			stat_last  <= beat.valid && beat.last_of_frame;
		end
	end

	assign stat = '{valid: stat_valid, activity: stat_act, last_of_frame: stat_last};

	// reader tagging must open a block at its top left pixel
	a_first_at_origin: assert property (@(posedge clk) disable iff (!rst_n)
		(beat.valid && beat.first_of_block) |-> (beat.px == '0 && beat.py == '0));

endmodule

`default_nettype wire

/* reader/block_reader.sv */
// reads a frame one 8x8 block at a time, one burst per block row, and tags
// each returned pixel with its position in the block and the frame
`default_nettype none
`include "noise_params.svh"

module block_reader import noise_pkg::*; (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire logic                frame_ready,     // level, sampled in idle
	input  wire logic [`DIM_W-1:0]   frame_width,
	input  wire logic [`DIM_W-1:0]   frame_height,
	input  wire logic [`ADDR_W-1:0]  frame_base,
	input  wire logic                rvalid,
	input  wire logic                rlast,
	input  wire logic [`PIXEL_W-1:0] rdata,
	input  wire logic                result_pending,  // previous estimate not yet taken
	output read_req_t                read_req,
	output pixel_beat_t              beat,
	output logic                     noise_estimation_en,
	output logic                     start_of_frame,
	output logic                     start_data
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_read,
		st_done
	} state_t;

	state_t state;
	state_t next_state;

	// frame geometry, latched when the frame is accepted
	logic [`ADDR_W-1:0] base_q;
	logic [`DIM_W-1:0]  width_q;
	logic [`DIM_W-1:0]  blocks_x;
	logic [`DIM_W-1:0]  blocks_y;

	logic [`BLOCK_LOG2-1:0] px;
	logic [`BLOCK_LOG2-1:0] py;
	logic [`DIM_W-1:0]      bcol;
	logic [`DIM_W-1:0]      brow;

	logic [`ADDR_W-1:0] addr_q;
	logic [`ADDR_W-1:0] next_addr;    // start of the following burst
	logic [`DIM_W-1:0]  next_line;
	logic [`DIM_W-1:0]  next_bcol;

	logic take;
	logic accept;
	logic px_last;
	logic py_last;
	logic col_last;
	logic row_last;
	logic block_end;
	logic frame_end;
	logic drained;

	// pixel tag registers
	logic                   beat_valid;
	logic                   beat_first;
	logic                   beat_last_blk;
	logic                   beat_last_frm;
	logic [`PIXEL_W-1:0]    beat_pixel;
	logic [`BLOCK_LOG2-1:0] beat_px;
	logic [`BLOCK_LOG2-1:0] beat_py;

	assign take      = rvalid && (state == st_read);
	assign accept    = (state == st_idle) && (next_state == st_request);
	assign px_last   = (px == `BLOCK_LOG2'(`BLOCK_SIZE - 1));
	assign py_last   = (py == `BLOCK_LOG2'(`BLOCK_SIZE - 1));
	assign col_last  = (bcol == blocks_x - `DIM_W'(1));
	assign row_last  = (brow == blocks_y - `DIM_W'(1));
	assign block_end = px_last && py_last;
	assign frame_end = block_end && col_last && row_last;

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (frame_ready && !result_pending) begin
					next_state = st_request;
				end
			end
			st_request: next_state = st_read;    // strobe lasts one cycle
			st_read: begin
				if (take && rlast) begin
					next_state = frame_end ? st_done : st_request;
				end
			end
			st_done: begin
				// two cycles let the last block reach the tracker
				if (drained) begin
					next_state = st_idle;
				end
			end
			default: next_state = st_idle;
		endcase
	end

	// line and block column of the burst after the current one
	always_comb begin
		next_line = (brow << `BLOCK_LOG2) + `DIM_W'(py) + `DIM_W'(1);
		next_bcol = bcol;
		if (py_last) begin
			next_bcol = col_last ? '0 : bcol + `DIM_W'(1);
			next_line = col_last ? (brow + `DIM_W'(1)) << `BLOCK_LOG2 : brow << `BLOCK_LOG2;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state          <= st_idle;
			drained        <= 1'b0;
			px             <= '0;
			py             <= '0;
			bcol           <= '0;
			brow           <= '0;
			beat_valid     <= 1'b0;
			beat_first     <= 1'b0;
			beat_last_blk  <= 1'b0;
			beat_last_frm  <= 1'b0;
			start_of_frame <= 1'b0;
			start_data     <= 1'b0;
		end else begin
			state   <= next_state;
			drained <= (state == st_done) && !drained;

			beat_valid     <= take;
			beat_first     <= take && (px == '0) && (py == '0);
			beat_last_blk  <= take && block_end;
			beat_last_frm  <= take && frame_end;
			start_data     <= take && (px == '0) && (py == '0);
			start_of_frame <= take && (px == '0) && (py == '0) && (bcol == '0) && (brow == '0);

			if (accept) begin
				px   <= '0;
				py   <= '0;
				bcol <= '0;
				brow <= '0;
			end else if (take) begin
				if (px_last) begin
					px <= '0;
					py <= py + 1'b1;
					if (py_last) begin
						py <= '0;
						if (col_last) begin
							bcol <= '0;
							brow <= row_last ? '0 : brow + `DIM_W'(1);
						end else begin
							bcol <= bcol + `DIM_W'(1);
						end
					end
				end else begin
					px <= px + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			base_q   <= frame_base;
			width_q  <= frame_width;
			blocks_x <= frame_width >> `BLOCK_LOG2;
			blocks_y <= frame_height >> `BLOCK_LOG2;
			addr_q   <= frame_base;
		end else if (take && rlast) begin
			addr_q <= next_addr;
		end
		// one beat ahead so the multiply has a full cycle
		if (take && px == `BLOCK_LOG2'(`BLOCK_SIZE - 2)) begin
			next_addr <= base_q + `ADDR_W'(next_line) * `ADDR_W'(width_q)
				+ (`ADDR_W'(next_bcol) << `BLOCK_LOG2);
		end
		if (take) begin
			beat_pixel <= rdata;
			beat_px    <= px;
			beat_py    <= py;
		end
	end

	assign noise_estimation_en = (state == st_read);

	assign read_req = '{start: (state == st_request), addr: addr_q,
		len: `LEN_W'(`BLOCK_SIZE)};

	assign beat = '{valid: beat_valid, pixel: beat_pixel, px: beat_px, py: beat_py,
		first_of_block: beat_first, last_of_block: beat_last_blk,
		last_of_frame: beat_last_frm};

	// memory closes a burst only on the last pixel of a block row
	a_rlast_on_row_end: assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && rlast) |-> px_last);

	a_no_beat_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> (state != st_idle));

endmodule

`default_nettype wire

/* common/noise_pkg.sv */
// types passed between the reader, the activity stage and the tracker
// import with a wildcard in the module header
`default_nettype none
`include "noise_params.svh"

package noise_pkg;

	// one burst request, start is a one-cycle strobe
	typedef struct packed {
		logic                start;
		logic [`ADDR_W-1:0]  addr;
		logic [`LEN_W-1:0]   len;    // beats in the burst
	} read_req_t;

	// one pixel tagged with its place in the block and the frame
	typedef struct packed {
		logic                   valid;
		logic [`PIXEL_W-1:0]    pixel;
		logic [`BLOCK_LOG2-1:0] px;  // column inside the block
		logic [`BLOCK_LOG2-1:0] py;  // row inside the block
		logic                   first_of_block;
		logic                   last_of_block;
		logic                   last_of_frame;
	} pixel_beat_t;

	// activity of one finished block
	typedef struct packed {
		logic               valid;
		logic [`ACT_W-1:0]  activity;
		logic               last_of_frame;
	} block_stat_t;

	typedef struct packed {
		logic [`ACT_W-1:0]  estimate;   // smallest block activity of the frame
		logic [`ADDR_W-1:0] base_addr;
	} noise_result_t;

endpackage

`default_nettype wire

/* common/noise_params.svh */
// sizes and widths shared by the noise estimation blocks
// include in every file that needs a width or the block size
`ifndef NOISE_PARAMS_SVH
`define NOISE_PARAMS_SVH

`define BLOCK_SIZE 8   // block edge in pixels
`define BLOCK_LOG2 3   // log2 of the block edge, also the width of px and py

`define PIXEL_W 8
`define ADDR_W 32      // byte address
`define DIM_W 16       // frame width and height

// enough for 56 differences of 255
`define ACT_W 16

`define LEN_W 4        // burst length field, holds BLOCK_SIZE

`endif
